// File: common/vec_front_pkg.sv
`default_nettype none

package vec_front_pkg;

    localparam int RF_ADDR_W = 10;  // vector rf address width

    localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
    localparam logic [11:0] CSR_CYCLE = 12'hC00;  // cycle counter read

    // major opcodes seen by the front end
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,  // only the cycle counter read
        OPC_VLE    = 7'b0000111,
        OPC_VSE    = 7'b0100111,
        OPC_OPV    = 7'b1010111,  // vmacc, vmv.vi, vsetivli
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_STREAM = 7'b1111111   // custom streamout
    } opcode_e;

    typedef enum logic [2:0] {
        VOP_VLE32,
        VOP_VSE32,
        VOP_VMACC,
        VOP_VMV_VI,
        VOP_STREAMOUT
    } vec_op_e;

    typedef enum logic [2:0] {
        SOP_LUI,
        SOP_ADDI,
        SOP_BNE,
        SOP_ADD,
        SOP_CSR,
        SOP_NONE
    } scalar_op_e;

    // queue word
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // command to the vector unit
    typedef struct packed {
        vec_op_e                op;
        logic [RF_ADDR_W-1:0]   vr_addr;
        logic [RF_ADDR_W-1:0]   vw_addr;
        logic [2:0]             vl;
        logic [11:0]            itr;
        logic [4:0]             imm5;
        logic [31:0]            base;    // x[rs1]
    } vec_cmd_t;

    typedef struct packed {
        logic        valid;
        scalar_op_e  op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;    // addi or lui immediate
        logic [31:0] pc;
        logic [11:0] b_imm;  // branch offset in halfwords
    } scalar_req_t;

endpackage

`default_nettype wire

// File: decoder/isa_decoder.sv
`default_nettype none

module isa_decoder
    import vec_front_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  fetch_entry_t head,
    input  logic         not_empty,
    input  logic         done_steady,
    input  logic         vec_ready,
    input  logic [31:0]  rs1_val,
    input  logic         redirect,
    output logic         pop,
    output logic         credit_ret,
    output scalar_req_t  scalar_req,
    output logic         vec_cmd_valid,
    output vec_cmd_t     vec_cmd,
    output logic         ap_done
);

    localparam logic [2:0] F3_VMACC    = 3'h0;
    localparam logic [2:0] F3_VMV_VI   = 3'h5;
    localparam logic [2:0] F3_VSETIVLI = 3'h7;
    localparam logic [2:0] F3_ADD      = 3'h0;
    localparam logic [2:0] F3_BNE      = 3'h1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_WAIT_DONE  // wfi taken, vector unit still busy
    } state_e;

    state_e     state;
    logic [31:0] instr;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        is_vec;
    logic        is_vset;
    logic        is_wfi;
    vec_op_e     vop;
    scalar_op_e  sop;
    logic [2:0]  vl;
    logic [11:0] itr;
    logic [4:0]  vr_idx;
    vec_cmd_t    next_cmd;

    // vl 0..4: low vl+1 index bits at the top; vl 5..7: vl-4 zeros above the index
    function automatic logic [RF_ADDR_W-1:0] map_addr(input logic [4:0] idx,
                                                      input logic [2:0] k);
        logic [4:0] masked;
        masked = (k >= 3'd4) ? idx : (idx & ~(5'h1f << (k + 3'd1)));
        return RF_ADDR_W'(masked) << (RF_ADDR_W - 1 - k);
    endfunction

    assign instr  = head.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign is_wfi = (instr == WFI_INSTR);

    always_comb begin
        is_vec  = 1'b0;
        is_vset = 1'b0;
        vop     = VOP_VLE32;
        sop     = SOP_NONE;
        case (opcode_e'(instr[6:0]))
            OPC_VLE: begin
                is_vec = 1'b1;
                vop    = VOP_VLE32;
            end
            OPC_VSE: begin
                is_vec = 1'b1;
                vop    = VOP_VSE32;
            end
            OPC_OPV: begin
                if (funct3 == F3_VMACC) begin
                    is_vec = 1'b1;
                    vop    = VOP_VMACC;
                end else if (funct3 == F3_VMV_VI) begin
                    is_vec = 1'b1;
                    vop    = VOP_VMV_VI;
                end else if (funct3 == F3_VSETIVLI) begin
                    is_vset = 1'b1;
                end
            end
            OPC_STREAM: begin
                is_vec = 1'b1;
                vop    = VOP_STREAMOUT;
            end
            OPC_LUI:    sop = SOP_LUI;
            OPC_OPIMM:  sop = (funct3 == 3'h0) ? SOP_ADDI : SOP_NONE;
            OPC_OP:     sop = (funct3 == F3_ADD && funct7 == 7'h0) ? SOP_ADD : SOP_NONE;
            OPC_BRANCH: sop = (funct3 == F3_BNE) ? SOP_BNE : SOP_NONE;
            OPC_LOAD:   sop = (instr[31:20] == CSR_CYCLE) ? SOP_CSR : SOP_NONE;
            default:    sop = SOP_NONE;
        endcase
    end

    // vector entries wait for a free or draining command register
    assign pop = (state == ST_RUN) && not_empty && (!is_vec || !vec_cmd_valid || vec_ready);
    assign credit_ret = pop && !redirect;  // flushed queue gets full credit anyway

    assign ap_done = (pop && is_wfi && done_steady) || (state == ST_WAIT_DONE && done_steady);

    always_comb begin
        scalar_req.valid = pop && (sop != SOP_NONE);
        scalar_req.op    = sop;
        scalar_req.rs1   = instr[19:15];  // also the base for vector commands
        scalar_req.rs2   = instr[24:20];
        scalar_req.rd    = instr[11:7];
        scalar_req.imm   = (sop == SOP_LUI) ? {instr[31:12], 12'h000}
                                            : {{20{instr[31]}}, instr[31:20]};
        scalar_req.pc    = head.pc;
        scalar_req.b_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};
    end

    assign vr_idx = (vop == VOP_VSE32) ? instr[11:7] : instr[24:20];

    always_comb begin
        next_cmd.op      = vop;
        next_cmd.vr_addr = map_addr(vr_idx, vl);
        next_cmd.vw_addr = map_addr(instr[11:7], vl);
        next_cmd.vl      = vl;
        next_cmd.itr     = itr;
        next_cmd.imm5    = instr[19:15];
        next_cmd.base    = rs1_val;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else if (start) begin
            state <= ST_RUN;
        end else begin
            case (state)
                ST_RUN: begin
                    if (pop && is_wfi) begin
                        state <= done_steady ? ST_IDLE : ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: if (done_steady) state <= ST_IDLE;
                default: state <= state;
            endcase
        end
    end

    // vsetivli config
    always_ff @(posedge clk) begin
        if (rst) begin
            vl  <= '0;
            itr <= '0;
        end else if (pop && is_vset) begin
            vl  <= instr[17:15];
            itr <= instr[29:18];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vec_cmd_valid <= 1'b0;
        end else if (pop && is_vec) begin
            vec_cmd_valid <= 1'b1;
        end else if (vec_ready) begin
            vec_cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && is_vec) begin
            vec_cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

// File: decoder/scalar_exec.sv
`default_nettype none

module scalar_exec
    import vec_front_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  scalar_req_t scalar_req,
    output logic [31:0] rs1_val,
    output logic        redirect,
    output logic [31:0] redirect_pc
);

    logic [31:0] regs [32];
    logic [31:0] rs2_val;
    logic [31:0] cycle_cnt;
    logic [31:0] wr_data;
    logic        wr_en;
    logic [31:0] b_offset;

    // x0 reads as zero and is never written
    assign rs1_val = (scalar_req.rs1 == 5'd0) ? 32'd0 : regs[scalar_req.rs1];
    assign rs2_val = (scalar_req.rs2 == 5'd0) ? 32'd0 : regs[scalar_req.rs2];

    always_comb begin
        wr_en   = scalar_req.valid && (scalar_req.rd != 5'd0);
        wr_data = 32'd0;
        case (scalar_req.op)
            SOP_ADD:  wr_data = rs1_val + rs2_val;
            SOP_ADDI: wr_data = rs1_val + scalar_req.imm;
            SOP_LUI:  wr_data = scalar_req.imm;
            SOP_CSR:  wr_data = cycle_cnt;
            default: begin
                wr_en   = 1'b0;  // bne has no writeback
                wr_data = 32'd0;
            end
        endcase
    end

    // write lands on the pop edge, so the next pop already sees it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[scalar_req.rd] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    // branch offset is in halfwords
    assign b_offset    = {{19{scalar_req.b_imm[11]}}, scalar_req.b_imm, 1'b0};
    assign redirect_pc = scalar_req.pc + b_offset;

    assign redirect = scalar_req.valid && (scalar_req.op == SOP_BNE) && (rs1_val != rs2_val);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_vec_front -Mdir obj_dir -f tb.f || exit 1
sim_out=$(./obj_dir/Vtb_vec_front 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Verification passed" && exit 0 || exit 1

// File: tb.f
common/vec_front_pkg.sv
verilog/instr_fetch.sv
verilog/instr_queue.sv
decoder/scalar_exec.sv
decoder/isa_decoder.sv
verilog/vec_front_top.sv
tb/vec_front_asserts.sv
tb/tb_vec_front.sv

// File: tb/tb_vec_front.sv
`default_nettype none

module tb_vec_front
    import vec_front_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int QUEUE_DEPTH = 4;
    localparam int PROG_DEPTH  = 64;
    localparam int CLK_PERIOD  = 40;
    localparam logic [31:0] WFI = 32'h1050_0073;
    // static lengths: init 32, scalar 12, vl map 25, branch 12, back-pressure 22, counter 6
    localparam int TOTAL_INSTRS = 109;
    localparam int WATCHDOG_NS  = 5 * TOTAL_INSTRS * CLK_PERIOD + 4000;
    localparam int MODEL_STEPS  = 1000;

    logic         clk;
    logic         rst;
    logic         prog_we;
    logic [5:0]   prog_addr;
    logic [31:0]  prog_data;
    logic         start;
    logic         done_steady;
    logic         vec_ready;
    logic         vec_cmd_valid;
    vec_cmd_t     vec_cmd;
    logic         ap_done;

    logic [31:0]  prog_img [PROG_DEPTH];
    int           prog_len;
    logic [31:0]  xr [32];       // reference scalar registers
    logic [2:0]   m_vl;
    logic [11:0]  m_itr;
    vec_cmd_t     exp_q [$];
    vec_cmd_t     got_q [$];
    int           done_count;
    int           error_count;
    bit           rand_ready;

    vec_front_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .PROG_DEPTH (PROG_DEPTH)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .start        (start),
        .done_steady  (done_steady),
        .vec_ready    (vec_ready),
        .vec_cmd_valid(vec_cmd_valid),
        .vec_cmd      (vec_cmd),
        .ap_done      (ap_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (rand_ready) begin
            vec_ready = ($urandom & 32'd1) != 32'd0;
        end else begin
            vec_ready = 1'b1;
        end
    end

    // accepted commands and done pulses
    always @(posedge clk) begin
        if (!rst && vec_cmd_valid && vec_ready) begin
            got_q.push_back(vec_cmd);
        end
        if (!rst && ap_done) begin
            done_count++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_with_error("watchdog expired before the directed tests finished");
    end

    // instruction encoders
    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] add(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic logic [31:0] bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] csr_cycle(input logic [4:0] rd);
        return {12'hC00, 5'd0, 3'b010, rd, 7'h03};
    endfunction

    function automatic logic [31:0] vsetivli(input logic [2:0] vl, input logic [11:0] itr);
        return {2'b11, itr, vl, 3'b111, 5'd0, 7'h57};
    endfunction

    function automatic logic [31:0] vle32(input logic [4:0] vd, input logic [4:0] rs1);
        return {7'h01, 5'd0, rs1, 3'b110, vd, 7'h07};
    endfunction

    function automatic logic [31:0] vse32(input logic [4:0] vs3, input logic [4:0] rs1);
        return {7'h01, 5'd0, rs1, 3'b110, vs3, 7'h27};
    endfunction

    function automatic logic [31:0] vmacc(input logic [4:0] vd, input logic [4:0] vs1,
                                          input logic [4:0] vs2);
        return {7'b1011011, vs2, vs1, 3'b000, vd, 7'h57};
    endfunction

    function automatic logic [31:0] vmv_vi(input logic [4:0] vd, input logic [4:0] imm);
        return {7'b0101111, 5'd0, imm, 3'b101, vd, 7'h57};
    endfunction

    function automatic logic [31:0] streamout(input logic [4:0] rs1);
        return {12'h000, rs1, 3'b000, 5'd0, 7'h7f};
    endfunction

    // index bits placed top-down, vl above 4 pushes them k-4 bits lower
    function automatic logic [RF_ADDR_W-1:0] expected_addr(input logic [4:0] idx,
                                                           input logic [2:0] k);
        logic [RF_ADDR_W-1:0] a;
        int nbits;
        int low;
        a = '0;
        nbits = (k <= 3'd4) ? int'(k) + 1 : 5;
        low = RF_ADDR_W - nbits - ((k > 3'd4) ? int'(k) - 4 : 0);
        for (int i = 0; i < nbits; i++) begin
            a[low + i] = idx[i];
        end
        return a;
    endfunction

    function automatic vec_cmd_t expect_cmd(input vec_op_e op, input logic [31:0] ins);
        vec_cmd_t c;
        logic [4:0] vr_idx;
        vr_idx    = (op == VOP_VSE32) ? ins[11:7] : ins[24:20];
        c.op      = op;
        c.vr_addr = expected_addr(vr_idx, m_vl);
        c.vw_addr = expected_addr(ins[11:7], m_vl);
        c.vl      = m_vl;
        c.itr     = m_itr;
        c.imm5    = ins[19:15];
        c.base    = xr[ins[19:15]];
        return c;
    endfunction

    task automatic stop_with_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic new_program();
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        prog_img[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = 6'(i);
            prog_data = prog_img[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // walks the program in order and lists the commands it should issue
    task automatic model_program();
        logic [31:0] mpc;
        logic [31:0] ins;
        logic [31:0] step;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          steps;
        mpc   = '0;
        steps = 0;
        exp_q.delete();
        ins = prog_img[0];
        while (ins != WFI && steps < MODEL_STEPS) begin
            rd   = ins[11:7];
            rs1  = ins[19:15];
            rs2  = ins[24:20];
            step = 32'd4;
            case (ins[6:0])
                7'h37: xr[rd] = {ins[31:12], 12'h000};
                7'h13: xr[rd] = xr[rs1] + {{20{ins[31]}}, ins[31:20]};
                7'h33: xr[rd] = xr[rs1] + xr[rs2];
                7'h63: begin
                    if (xr[rs1] != xr[rs2]) begin
                        step = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'h57: begin
                    if (ins[14:12] == 3'd7) begin
                        m_vl  = ins[17:15];
                        m_itr = ins[29:18];
                    end else if (ins[14:12] == 3'd0) begin
                        exp_q.push_back(expect_cmd(VOP_VMACC, ins));
                    end else if (ins[14:12] == 3'd5) begin
                        exp_q.push_back(expect_cmd(VOP_VMV_VI, ins));
                    end
                end
                7'h07: exp_q.push_back(expect_cmd(VOP_VLE32, ins));
                7'h27: exp_q.push_back(expect_cmd(VOP_VSE32, ins));
                7'h7f: exp_q.push_back(expect_cmd(VOP_STREAMOUT, ins));
                default: ;
            endcase
            xr[0] = '0;
            mpc   = mpc + step;
            ins   = prog_img[mpc[7:2]];
            steps++;
        end
        if (steps >= MODEL_STEPS) begin
            stop_with_error("reference model never reached wfi");
        end
    endtask

    task automatic start_program();
        @(negedge clk);
        got_q.delete();
        done_count = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done();
        while (done_count == 0) begin
            @(negedge clk);
        end
        while (vec_cmd_valid) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_eq("ap_done pulses", 128'(done_count), 128'(1));
    endtask

    task automatic compare_cmds();
        check_eq("command count", 128'(got_q.size()), 128'(exp_q.size()));
        foreach (exp_q[i]) begin
            check_eq($sformatf("vec_cmd[%0d].op", i), 128'(got_q[i].op), 128'(exp_q[i].op));
            check_eq($sformatf("vec_cmd[%0d].vr_addr", i), 128'(got_q[i].vr_addr),
                     128'(exp_q[i].vr_addr));
            check_eq($sformatf("vec_cmd[%0d].vw_addr", i), 128'(got_q[i].vw_addr),
                     128'(exp_q[i].vw_addr));
            check_eq($sformatf("vec_cmd[%0d].vl", i), 128'(got_q[i].vl), 128'(exp_q[i].vl));
            check_eq($sformatf("vec_cmd[%0d].itr", i), 128'(got_q[i].itr), 128'(exp_q[i].itr));
            check_eq($sformatf("vec_cmd[%0d].imm5", i), 128'(got_q[i].imm5),
                     128'(exp_q[i].imm5));
            check_eq($sformatf("vec_cmd[%0d].base", i), 128'(got_q[i].base),
                     128'(exp_q[i].base));
        end
    endtask

    task automatic run_program();
        load_program();
        model_program();
        start_program();
        wait_for_done();
        compare_cmds();
    endtask

    // every register gets a known value before any program reads it
    task automatic initialize_registers();
        new_program();
        for (int i = 1; i < 32; i++) begin
            emit(addi(5'(i), 5'd0, 12'(i * 97 + 3)));
        end
        emit(WFI);
        run_program();
    endtask

    task automatic scalar_base_addresses();
        new_program();
        emit(vsetivli(3'd2, 12'd5));
        emit(lui(5'd1, 20'h12345));
        emit(addi(5'd1, 5'd1, 12'h678));
        emit(lui(5'd2, 20'hFFFFF));
        emit(addi(5'd2, 5'd2, 12'hFFF));  // -1
        emit(add(5'd3, 5'd1, 5'd2));      // wraps past 2^32
        emit(addi(5'd4, 5'd0, 12'h7FF));
        emit(vle32(5'd1, 5'd1));
        emit(vse32(5'd5, 5'd3));
        emit(vle32(5'd2, 5'd4));
        emit(streamout(5'd2));
        emit(WFI);
        run_program();
        check_eq("vse32 base", 128'(got_q[1].base), 128'(32'h1234_4677));
    endtask

    task automatic vl_address_mapping();
        new_program();
        for (int k = 0; k < 8; k++) begin
            emit(vsetivli(3'(k), 12'(k * 37 + 1)));
            emit(vmacc(5'(k * 3 + 1), 5'(k + 2), 5'(31 - k)));
            emit(vmv_vi(5'(k + 9), 5'(k * 5 + 3)));
        end
        emit(WFI);
        run_program();
    endtask

    task automatic branch_paths();
        new_program();
        emit(vsetivli(3'd3, 12'd2));
        emit(addi(5'd5, 5'd0, 12'd3));      // loop count
        emit(addi(5'd6, 5'd0, 12'd0));
        emit(vle32(5'd4, 5'd5));
        emit(addi(5'd5, 5'd5, 12'hFFF));
        emit(bne(5'd5, 5'd6, 13'(-8)));     // back to the vle32
        emit(bne(5'd5, 5'd6, 13'd8));       // falls through
        emit(vse32(5'd3, 5'd7));
        emit(bne(5'd1, 5'd6, 13'd8));       // skips the vmacc
        emit(vmacc(5'd1, 5'd2, 5'd3));
        emit(streamout(5'd5));
        emit(WFI);
        run_program();
    endtask

    task automatic random_backpressure();
        new_program();
        emit(vsetivli(3'd6, 12'd100));
        for (int i = 0; i < 20; i++) begin
            case (i % 5)
                0: emit(vle32(5'(i), 5'(i + 1)));
                1: emit(vse32(5'(i + 2), 5'(i)));
                2: emit(vmacc(5'(i), 5'(i + 3), 5'(i + 7)));
                3: emit(vmv_vi(5'(i), 5'(i * 3)));
                default: emit(streamout(5'(31 - i)));
            endcase
        end
        emit(WFI);
        rand_ready = 1'b1;
        run_program();
        rand_ready = 1'b0;
        check_eq("back-pressure command count", 128'(got_q.size()), 128'(20));
    endtask

    task automatic cycle_counter_and_done();
        new_program();
        emit(csr_cycle(5'd8));
        emit(addi(5'd10, 5'd0, 12'd1));
        emit(csr_cycle(5'd9));
        emit(vle32(5'd1, 5'd8));
        emit(vle32(5'd2, 5'd9));
        emit(WFI);
        load_program();
        done_steady = 1'b0;
        start_program();
        while (got_q.size() < 2) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        check_eq("ap_done while not steady", 128'(done_count), 128'(0));
        done_steady = 1'b1;
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
        check_eq("ap_done pulses", 128'(done_count), 128'(1));
        check_eq("commands after ap_done", 128'(got_q.size()), 128'(2));
        check_eq("vec_cmd[0].op", 128'(got_q[0].op), 128'(VOP_VLE32));
        check_eq("cycle counter increases", 128'(got_q[1].base > got_q[0].base), 128'(1));
    endtask

    initial begin
        void'($urandom(32'h225c_8ade));
        clk         = 1'b0;
        rst         = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        start       = 1'b0;
        done_steady = 1'b1;
        vec_ready   = 1'b1;
        rand_ready  = 1'b0;
        prog_len    = 0;
        done_count  = 0;
        error_count = 0;
        m_vl        = '0;
        m_itr       = '0;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        initialize_registers();
        scalar_base_addresses();
        vl_address_mapping();
        branch_paths();
        random_backpressure();
        cycle_counter_and_done();

        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/vec_front_asserts.sv
`default_nettype none

module vec_front_asserts
    import vec_front_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                               clk,
    input logic                               rst,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]   credits,
    input logic                               push,
    input logic                               vec_cmd_valid,
    input logic                               vec_ready,
    input vec_cmd_t                           vec_cmd,
    input logic                               ap_done
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    credit_limit: assert property (@(posedge clk) disable iff (rst)
        credits <= CW'(QUEUE_DEPTH))
        else $error("credit count above queue depth");

    push_needs_credit: assert property (@(posedge clk) disable iff (rst)
        push |-> credits != '0)
        else $error("push into a full queue");

    // command held until the vector unit takes it
    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        vec_cmd_valid && !vec_ready |=> vec_cmd_valid && $stable(vec_cmd))
        else $error("vec_cmd changed or dropped before acceptance");

    done_single: assert property (@(posedge clk) disable iff (rst)
        ap_done |=> !ap_done)
        else $error("ap_done longer than one cycle");

endmodule

bind instr_fetch vec_front_asserts #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetch_asserts (
    .clk          (clk),
    .rst          (rst),
    .credits      (credits),
    .push         (1'b0),
    .vec_cmd_valid(1'b0),
    .vec_ready    (1'b1),
    .vec_cmd      ('0),
    .ap_done      (1'b0)
);

bind instr_queue vec_front_asserts #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_asserts (
    .clk          (clk),
    .rst          (rst),
    .credits      (CW'(QUEUE_DEPTH) - count),  // free slots left in the queue
    .push         (push),
    .vec_cmd_valid(1'b0),
    .vec_ready    (1'b1),
    .vec_cmd      ('0),
    .ap_done      (1'b0)
);

bind isa_decoder vec_front_asserts decoder_asserts (
    .clk          (clk),
    .rst          (rst),
    .credits      ('0),
    .push         (1'b0),
    .vec_cmd_valid(vec_cmd_valid),
    .vec_ready    (vec_ready),
    .vec_cmd      (vec_cmd),
    .ap_done      (ap_done)
);

`default_nettype wire

// File: verilog/instr_fetch.sv
`default_nettype none

module instr_fetch
    import vec_front_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int PROG_DEPTH  = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  logic                          start,
    input  logic                          credit_ret,
    input  logic                          redirect,
    input  logic [31:0]                   redirect_pc,
    output logic                          push,
    output fetch_entry_t                  push_entry
);

    localparam int AW = $clog2(PROG_DEPTH);
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    logic [31:0]   prog_mem [PROG_DEPTH];
    logic [31:0]   rdata;      // always holds prog_mem at pc
    logic [31:0]   pc;
    logic [31:0]   pc_next;
    logic          running;
    logic [CW-1:0] credits;
    logic          push_wfi;

    // one entry per cycle as long as a queue slot is owed to us
    assign push       = running && (credits != '0);
    assign push_entry = '{pc: pc, instr: rdata};
    assign push_wfi   = push && (rdata == WFI_INSTR);

    always_comb begin
        pc_next = pc;
        if (start) begin
            pc_next = '0;
        end else if (redirect) begin
            pc_next = redirect_pc;  // taken bne
        end else if (push) begin
            pc_next = pc + 32'd4;
        end
    end

    // read address runs one step ahead so rdata lines up with pc
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
        rdata <= prog_mem[pc_next[AW+1:2]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
        end else begin
            pc <= pc_next;
            if (start || redirect) begin
                running <= 1'b1;
            end else if (push_wfi) begin
                running <= 1'b0;  // nothing after wfi is fetched
            end
        end
    end

    // queue is emptied on redirect, so all slots come back at once
    always_ff @(posedge clk) begin
        if (rst || start || redirect) begin
            credits <= CW'(QUEUE_DEPTH);
        end else begin
            credits <= credits - CW'(push) + CW'(credit_ret);
        end
    end

endmodule

`default_nettype wire

// File: verilog/instr_queue.sv
`default_nettype none

module instr_queue
    import vec_front_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         push,
    input  fetch_entry_t push_entry,
    input  logic         pop,
    input  logic         flush,
    output fetch_entry_t head,
    output logic         not_empty
);

    localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    fetch_entry_t  entries [QUEUE_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign head      = entries[rd_ptr];  // fall-through head
    assign do_pop    = pop && not_empty;

    // no full check, fetch only pushes against a credit
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CW'(push) - CW'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: verilog/vec_front_top.sv
`default_nettype none

module vec_front_top
    import vec_front_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int PROG_DEPTH  = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  logic                          start,
    input  logic                          done_steady,
    input  logic                          vec_ready,
    output logic                          vec_cmd_valid,
    output vec_cmd_t                      vec_cmd,
    output logic                          ap_done
);

    logic         push;
    fetch_entry_t push_entry;
    fetch_entry_t head;
    logic         not_empty;
    logic         pop;
    logic         credit_ret;
    scalar_req_t  scalar_req;
    logic [31:0]  rs1_val;
    logic         redirect;
    logic [31:0]  redirect_pc;

    instr_fetch #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .PROG_DEPTH (PROG_DEPTH)
    ) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .start      (start),
        .credit_ret (credit_ret),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .push       (push),
        .push_entry (push_entry)
    );

    instr_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_entry(push_entry),
        .pop       (pop),
        .flush     (redirect),  // taken bne drops everything fetched behind it
        .head      (head),
        .not_empty (not_empty)
    );

    isa_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .head         (head),
        .not_empty    (not_empty),
        .done_steady  (done_steady),
        .vec_ready    (vec_ready),
        .rs1_val      (rs1_val),
        .redirect     (redirect),
        .pop          (pop),
        .credit_ret   (credit_ret),
        .scalar_req   (scalar_req),
        .vec_cmd_valid(vec_cmd_valid),
        .vec_cmd      (vec_cmd),
        .ap_done      (ap_done)
    );

    scalar_exec u_scalar (
        .clk        (clk),
        .rst        (rst),
        .scalar_req (scalar_req),
        .rs1_val    (rs1_val),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire
